// ==== logic/malloc_mem_pkg.sv ====
// Allocating buffer memory package with sizes, address and bank-port structs, and FSM states.
`default_nettype none

package malloc_mem_pkg;

  localparam int num_wr_ports = 2;
  localparam int num_banks    = 4;
  localparam int bank_bits    = 2;
  localparam int num_rows     = 16;
  localparam int row_bits     = 4;
  localparam int data_width   = 16;

  // External address as seen on adr and rd_adr.
  typedef struct packed {
    logic [bank_bits-1:0] bank;
    logic [row_bits-1:0]  row;
  } addr_t;

  typedef struct packed {
    logic                  en;
    logic [row_bits-1:0]   row;
    logic [data_width-1:0] data;
  } mem_wr_t;  // One bank write.

  typedef struct packed {
    logic                en;
    logic [row_bits-1:0] row;
  } mem_rd_t;  // One bank read.

  typedef enum logic {
    FL_INIT,  // Loading rows 0 to 15.
    FL_RUN
  } fl_state_t;

endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
// Free list holding the free row numbers of one bank in a register FIFO, filled at reset.
`default_nettype none
`timescale 1ns/1ps

module free_list import malloc_mem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pop,
  input  logic                push,
  input  logic [row_bits-1:0] push_row,
  output logic [row_bits-1:0] head,
  output logic                empty,
  output logic                ready
);

  fl_state_t           state;
  logic [row_bits-1:0] init_cnt;
  logic [row_bits-1:0] rd_ptr;
  logic [row_bits-1:0] wr_ptr;
  logic [row_bits:0]   count;     // Holds 0 to num_rows.
  logic [row_bits-1:0] fifo [num_rows];
  logic                wr_en;
  logic [row_bits-1:0] wr_row;
  logic                rd_en;

  // Init counter owns the write side until every row is loaded.
  assign wr_en  = (state == FL_INIT) || push;
  assign wr_row = (state == FL_INIT) ? init_cnt : push_row;
  assign rd_en  = (state == FL_RUN) && pop && !empty;

  assign head  = fifo[rd_ptr];  // Oldest free row.
  assign empty = (count == '0);
  assign ready = (state == FL_RUN);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= FL_INIT;
      init_cnt <= '0;
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
    end else begin
      if (state == FL_INIT) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == row_bits'(num_rows - 1)) begin
          state <= FL_RUN;  // Last row written this edge.
        end
      end
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push with pop leaves it unchanged.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo[wr_ptr] <= wr_row;
    end
  end

endmodule

`default_nettype wire

// ==== logic/alloc_ctrl.sv ====
// Allocation control that maps each write port to a distinct non-empty bank and drives bp.
`default_nettype none
`timescale 1ns/1ps

module alloc_ctrl import malloc_mem_pkg::*; (
  input  logic [num_wr_ports-1:0]                 write,
  input  logic [num_wr_ports-1:0][data_width-1:0] din,
  input  logic [num_banks-1:0]                    empty,
  input  logic [num_banks-1:0][row_bits-1:0]      head,
  input  logic                                    ready,
  output addr_t [num_wr_ports-1:0]                adr,
  output logic [num_wr_ports-1:0]                 bp,
  output logic [num_banks-1:0]                    pop,
  output mem_wr_t [num_banks-1:0]                 bank_wr
);

  logic [num_wr_ports-1:0]                found;
  logic [num_wr_ports-1:0][bank_bits-1:0] sel_bank;

  // Port N gets the N-th non-empty bank, counting up from bank 0.
  always_comb begin : rank_banks
    int rank;
    rank     = 0;
    found    = '0;
    sel_bank = '0;
    for (int b = 0; b < num_banks; b++) begin
      if (!empty[b] && (rank < num_wr_ports)) begin
        sel_bank[rank] = bank_bits'(b);
        found[rank]    = 1'b1;
        rank           = rank + 1;
      end
    end
  end

  always_comb begin : drive_ports
    pop     = '0;
    bank_wr = '0;
    for (int p = 0; p < num_wr_ports; p++) begin
      bp[p]       = !ready || !found[p];  // No bank left for this port.
      adr[p].bank = sel_bank[p];
      adr[p].row  = head[sel_bank[p]];
      if (write[p] && !bp[p]) begin
        pop[sel_bank[p]]          = 1'b1;
        bank_wr[sel_bank[p]].en   = 1'b1;
        bank_wr[sel_bank[p]].row  = head[sel_bank[p]];
        bank_wr[sel_bank[p]].data = din[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/read_ctrl.sv ====
// Read control that issues bank reads, returns data with a valid pulse and frees dequeued rows.
`default_nettype none
`timescale 1ns/1ps

module read_ctrl import malloc_mem_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 read,
  input  logic                                 deq,
  input  addr_t                                rd_adr,
  output mem_rd_t [num_banks-1:0]              bank_rd,
  input  logic [num_banks-1:0][data_width-1:0] bank_data,
  output logic [num_banks-1:0]                 push,
  output logic [row_bits-1:0]                  push_row,
  output logic [data_width-1:0]                rd_dout,
  output logic                                 rd_vld
);

  logic [bank_bits-1:0] vld_bank;  // Bank whose data returns this cycle.

  // Only the addressed bank sees the read.
  always_comb begin
    bank_rd = '0;
    push    = '0;
    bank_rd[rd_adr.bank].en  = read;
    bank_rd[rd_adr.bank].row = rd_adr.row;
    push[rd_adr.bank]        = read && deq;  // Row is free from the next cycle.
  end

  assign push_row = rd_adr.row;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld   <= 1'b0;
      vld_bank <= '0;
    end else begin
      rd_vld   <= read;
      vld_bank <= rd_adr.bank;
    end
  end

  assign rd_dout = bank_data[vld_bank];  // Bank output is already registered.

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
// Bank memory model with one write and one read port and a registered read output.
`default_nettype none
`timescale 1ns/1ps

module sram_bank import malloc_mem_pkg::*; (
  input  logic                  clk,
  input  mem_wr_t               wr,
  input  mem_rd_t               rd,
  output logic [data_width-1:0] rd_data
);

  logic [data_width-1:0] mem [num_rows];

  // Read samples before the write lands, so a same-row write returns old data.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr.data;
    end
    if (rd.en) begin
      rd_data <= mem[rd.row];
    end
  end

endmodule

`default_nettype wire

// ==== logic/malloc_mem_core.sv ====
// Allocating buffer core with the bank free lists, allocation control and read path.
`default_nettype none
`timescale 1ns/1ps

module malloc_mem_core import malloc_mem_pkg::*; (
  input  logic                                    clk,
  input  logic                                    rst_n,
  output logic                                    ready,
  input  logic [num_wr_ports-1:0]                 write,
  input  logic [num_wr_ports-1:0][data_width-1:0] din,
  output addr_t [num_wr_ports-1:0]                adr,
  output logic [num_wr_ports-1:0]                 bp,
  input  logic                                    read,
  input  logic                                    deq,
  input  addr_t                                   rd_adr,
  output logic [data_width-1:0]                   rd_dout,
  output logic                                    rd_vld,
  output mem_wr_t [num_banks-1:0]                 bank_wr,
  output mem_rd_t [num_banks-1:0]                 bank_rd,
  input  logic [num_banks-1:0][data_width-1:0]    bank_data
);

  logic [num_banks-1:0]               fl_pop;
  logic [num_banks-1:0]               fl_push;
  logic [num_banks-1:0]               fl_empty;
  logic [num_banks-1:0]               fl_ready;
  logic [num_banks-1:0][row_bits-1:0] fl_head;
  logic [row_bits-1:0]                push_row;

  for (genvar b = 0; b < num_banks; b++) begin : g_fl
    free_list i_fl (
      .clk      (clk),
      .rst_n    (rst_n),
      .pop      (fl_pop[b]),
      .push     (fl_push[b]),
      .push_row (push_row),
      .head     (fl_head[b]),
      .empty    (fl_empty[b]),
      .ready    (fl_ready[b])
    );
  end

  assign ready = &fl_ready;  // All lists loaded.

  alloc_ctrl i_alloc (
    .write   (write),
    .din     (din),
    .empty   (fl_empty),
    .head    (fl_head),
    .ready   (ready),
    .adr     (adr),
    .bp      (bp),
    .pop     (fl_pop),
    .bank_wr (bank_wr)
  );

  read_ctrl i_read (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .deq       (deq),
    .rd_adr    (rd_adr),
    .bank_rd   (bank_rd),
    .bank_data (bank_data),
    .push      (fl_push),
    .push_row  (push_row),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld)
  );

endmodule

`default_nettype wire

// ==== logic/malloc_mem_top.sv ====
// Allocating buffer memory top level joining the core to its four bank memories.
`default_nettype none
`timescale 1ns/1ps

module malloc_mem_top import malloc_mem_pkg::*; (
  input  logic                                    clk,
  input  logic                                    rst_n,
  output logic                                    ready,
  input  logic [num_wr_ports-1:0]                 write,
  input  logic [num_wr_ports-1:0][data_width-1:0] din,
  output addr_t [num_wr_ports-1:0]                adr,
  output logic [num_wr_ports-1:0]                 bp,
  input  logic                                    read,
  input  logic                                    deq,
  input  addr_t                                   rd_adr,
  output logic [data_width-1:0]                   rd_dout,
  output logic                                    rd_vld
);

  mem_wr_t [num_banks-1:0]              bank_wr;
  mem_rd_t [num_banks-1:0]              bank_rd;
  logic [num_banks-1:0][data_width-1:0] bank_data;

  malloc_mem_core i_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready     (ready),
    .write     (write),
    .din       (din),
    .adr       (adr),
    .bp        (bp),
    .read      (read),
    .deq       (deq),
    .rd_adr    (rd_adr),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld),
    .bank_wr   (bank_wr),
    .bank_rd   (bank_rd),
    .bank_data (bank_data)
  );

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    sram_bank i_bank (
      .clk     (clk),
      .wr      (bank_wr[b]),
      .rd      (bank_rd[b]),
      .rd_data (bank_data[b])
    );
  end

endmodule

`default_nettype wire

// ==== verification/malloc_mem_tb.sv ====
// Allocating buffer memory testbench with shadow free lists, reference allocation and checks.
`default_nettype none
`timescale 1ns/1ps

module malloc_mem_tb import malloc_mem_pkg::*; ();

  localparam int clk_half      = 4;
  localparam int reset_cycles  = 16;
  localparam int ready_timeout = 100;
  localparam int random_cycles = 500;
  localparam int sample_delay  = 2;  // Between falling and rising edge.

  logic                                    clk;
  logic                                    rst_n;
  logic                                    ready;
  logic [num_wr_ports-1:0]                 write;
  logic [num_wr_ports-1:0][data_width-1:0] din;
  addr_t [num_wr_ports-1:0]                adr;
  logic [num_wr_ports-1:0]                 bp;
  logic                                    read;
  logic                                    deq;
  addr_t                                   rd_adr;
  logic [data_width-1:0]                   rd_dout;
  logic                                    rd_vld;

  integer                seed;
  int                    err_cnt = 0;
  int                    timeout_cnt = 0;
  logic [row_bits-1:0]   free_q [num_banks][$];  // Shadow free lists.
  logic [data_width-1:0] shadow_mem [num_banks][num_rows];
  addr_t                 used_q [$];  // Allocated and not yet dequeued.

  malloc_mem_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready   (ready),
    .write   (write),
    .din     (din),
    .adr     (adr),
    .bp      (bp),
    .read    (read),
    .deq     (deq),
    .rd_adr  (rd_adr),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_half) clk = ~clk;
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Port N takes the N-th bank with free rows, at that bank's oldest free row.
  function automatic void expected_alloc(input logic rdy,
                                         output addr_t [num_wr_ports-1:0] exp_adr,
                                         output logic [num_wr_ports-1:0] exp_bp);
    int p;
    p       = 0;
    exp_adr = '0;
    exp_bp  = '1;
    for (int b = 0; b < num_banks; b++) begin
      if (rdy && (free_q[b].size() > 0) && (p < num_wr_ports)) begin
        exp_adr[p].bank = bank_bits'(b);
        exp_adr[p].row  = free_q[b][0];
        exp_bp[p]       = 1'b0;
        p++;
      end
    end
  endfunction

  task automatic drive_cycle(input logic [num_wr_ports-1:0] w, input logic rd,
                             input logic dq, input addr_t ra);
    @(negedge clk);
    write  = w;
    din[0] = data_width'($random(seed));
    din[1] = data_width'($random(seed));
    read   = rd;
    deq    = dq;
    rd_adr = ra;
  endtask

  task automatic read_addr(input addr_t ra, input logic dq);
    if (dq) begin
      for (int i = 0; i < used_q.size(); i++) begin
        if (used_q[i] == ra) begin
          used_q.delete(i);
          break;
        end
      end
    end
    drive_cycle('0, 1'b1, dq, ra);
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready && (cycles < ready_timeout)) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      timeout_cnt++;
      $display("Timed out after %0d cycles waiting for ready to rise", cycles);
    end
  endtask

  initial begin : compare
    addr_t [num_wr_ports-1:0] exp_adr;
    logic [num_wr_ports-1:0]  exp_bp;
    logic                     model_ready;
    logic                     rd_pending;
    logic [data_width-1:0]    rd_expect;
    int                       init_edges;
    rd_pending = 1'b0;
    rd_expect  = '0;
    init_edges = 0;
    for (int b = 0; b < num_banks; b++) begin
      for (int r = 0; r < num_rows; r++) begin
        free_q[b].push_back(row_bits'(r));  // Rows leave in order 0 to 15 first.
      end
    end
    forever begin
      @(negedge clk);
      #(sample_delay);
      model_ready = (init_edges >= num_rows);
      check_eq(32'(ready), 32'(model_ready), "ready");
      expected_alloc(model_ready, exp_adr, exp_bp);
      check_eq(32'(bp), 32'(exp_bp), "bp");
      check_eq(32'(rd_vld), 32'(rd_pending), "rd_vld");
      if (rd_pending) begin
        check_eq(32'(rd_dout), 32'(rd_expect), "rd_dout");
      end
      // Read sees the data before this cycle's writes land.
      rd_pending = read;
      if (read) begin
        rd_expect = shadow_mem[rd_adr.bank][rd_adr.row];
      end
      for (int p = 0; p < num_wr_ports; p++) begin
        if (write[p] && !exp_bp[p]) begin
          check_eq(32'(adr[p]), 32'(exp_adr[p]), $sformatf("adr of port %0d", p));
          shadow_mem[exp_adr[p].bank][exp_adr[p].row] = din[p];
          void'(free_q[exp_adr[p].bank].pop_front());
          used_q.push_back(exp_adr[p]);
        end
      end
      if (read && deq) begin
        free_q[rd_adr.bank].push_back(rd_adr.row);  // Tail of its bank's list.
      end
      if (rst_n && (init_edges < num_rows)) begin
        init_edges++;
      end
    end
  end

  initial begin : stimulus
    addr_t                   ra;
    logic [num_wr_ports-1:0] w;
    logic                    rd;
    logic                    dq;
    int                      idx;
    seed   = 32'hdb98_f336;
    rst_n  = 1'b0;
    write  = '0;
    din    = '0;
    read   = 1'b0;
    deq    = 1'b0;
    rd_adr = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    wait_ready();
    if (timeout_cnt == 0) begin
      for (int i = 0; i < 8; i++) begin
        drive_cycle(2'b11, 1'b0, 1'b0, '0);
        check_eq(32'(adr[0].bank != adr[1].bank), 32'd1, "distinct port banks");
      end
      // Banks 0 and 1 hold 8 free rows each, so 32 more leave only bank 3.
      repeat (32) drive_cycle(2'b01, 1'b0, 1'b0, '0);
      drive_cycle('0, 1'b0, 1'b0, '0);
      check_eq(32'(bp), 32'(2'b10), "bp with one bank left");
      repeat (num_rows) drive_cycle(2'b01, 1'b0, 1'b0, '0);
      drive_cycle('0, 1'b0, 1'b0, '0);
      check_eq(32'(bp), 32'(2'b11), "bp with all banks full");
      for (int i = 0; i < used_q.size(); i++) begin
        read_addr(used_q[i], 1'b0);
      end
      // Freed out of order, so bank 0 must hand back rows 2, 0, 1.
      read_addr({2'd0, 4'd2}, 1'b1);
      read_addr({2'd0, 4'd0}, 1'b1);
      read_addr({2'd0, 4'd1}, 1'b1);
      repeat (3) drive_cycle(2'b01, 1'b0, 1'b0, '0);
      for (int c = 0; c < random_cycles; c++) begin
        w  = num_wr_ports'($random(seed));
        rd = 1'b0;
        dq = 1'b0;
        ra = '0;
        if ((used_q.size() > 0) && 1'($random(seed))) begin
          idx = $unsigned($random(seed)) % used_q.size();
          ra  = used_q[idx];
          rd  = 1'b1;
          dq  = 1'($random(seed));
          if (dq) begin
            used_q.delete(idx);
          end
        end
        drive_cycle(w, rd, dq, ra);
      end
    end
    repeat (2) drive_cycle('0, 1'b0, 1'b0, '0);
    $display("Errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if ((err_cnt == 0) && (timeout_cnt == 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== malloc_mem.f ====
logic/malloc_mem_pkg.sv
logic/free_list.sv
logic/alloc_ctrl.sv
logic/read_ctrl.sv
logic/sram_bank.sv
logic/malloc_mem_core.sv
logic/malloc_mem_top.sv
verification/malloc_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= malloc_mem_tb
FILELIST  ?= malloc_mem.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
